// ==== sim.f ====
rtl/mem_isa_pkg.sv
rtl/cp0_pkg.sv
rtl/cp0_bypass.sv
rtl/except_resolve.sv
rtl/mem_access_format.sv
rtl/mem_access_ctrl.sv
rtl/mem_stage.sv
tb/mem_stage_properties.sv
tb/tb_mem_stage.sv

// ==== Makefile ====
TOP := tb_mem_stage

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// ==== tb/tb_mem_stage.sv ====
`timescale 1ns/10ps

module tb_mem_stage;
    import mem_isa_pkg::*;

    localparam logic [31:0] alu_result  = 32'hc0de_5a5a;
    localparam logic [31:0] cp0_epc_val = 32'h0000_1234;
    localparam logic [31:0] pc_val      = 32'h0040_0010;
    localparam logic [7:0]  op_addu     = 8'h21;

    typedef struct packed {
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] reg2;
        logic [31:0] flags;
        logic [31:0] inst_addr;
        logic [31:0] status;
        logic [31:0] cause;
        logic        wb_we;
        logic [4:0]  wb_addr;
        logic [31:0] wb_data;
        logic [31:0] exp_wdata;
        logic [31:0] exp_exc;
        logic [31:0] exp_epc;
        logic        chk_mem;
        logic [31:0] exp_mem;
        logic        no_xfer;
    } row_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        i_valid;
    logic [7:0]  i_aluop;
    logic [31:0] i_addr;
    logic [31:0] i_reg2;
    logic [4:0]  i_wd;
    logic        i_wreg;
    logic [31:0] i_wdata;
    logic [31:0] i_excepttype;
    logic [31:0] i_inst_addr;
    logic [31:0] i_cp0_status;
    logic [31:0] i_cp0_cause;
    logic [31:0] i_cp0_epc;
    logic        i_wb_cp0_we;
    logic [4:0]  i_wb_cp0_addr;
    logic [31:0] i_wb_cp0_data;
    logic [31:0] i_prdata = '0;
    logic        i_pready = 1'b0;
    logic        o_ready;
    logic [31:0] o_paddr;
    logic        o_psel;
    logic        o_penable;
    logic        o_pwrite;
    logic [3:0]  o_pstrb;
    logic [31:0] o_pwdata;
    logic        o_wb_valid;
    logic [4:0]  o_wb_wd;
    logic        o_wb_wreg;
    logic [31:0] o_wb_wdata;
    logic [31:0] o_wb_excepttype;
    logic [31:0] o_wb_cp0_epc;

    logic [31:0] mem [0:15];
    int unsigned wait_cnt;
    row_t        rows[$];

    always #5 clk = ~clk;

    mem_stage #(
        .ADDR_W(32)
    ) u_dut (
        .clk            (clk),
        .rst            (rst),
        .i_valid        (i_valid),
        .o_ready        (o_ready),
        .i_aluop        (i_aluop),
        .i_addr         (i_addr),
        .i_reg2         (i_reg2),
        .i_wd           (i_wd),
        .i_wreg         (i_wreg),
        .i_wdata        (i_wdata),
        .i_excepttype   (i_excepttype),
        .i_inst_addr    (i_inst_addr),
        .i_cp0_status   (i_cp0_status),
        .i_cp0_cause    (i_cp0_cause),
        .i_cp0_epc      (i_cp0_epc),
        .i_wb_cp0_we    (i_wb_cp0_we),
        .i_wb_cp0_addr  (i_wb_cp0_addr),
        .i_wb_cp0_data  (i_wb_cp0_data),
        .o_paddr        (o_paddr),
        .o_psel         (o_psel),
        .o_penable      (o_penable),
        .o_pwrite       (o_pwrite),
        .o_pstrb        (o_pstrb),
        .o_pwdata       (o_pwdata),
        .i_prdata       (i_prdata),
        .i_pready       (i_pready),
        .o_wb_valid     (o_wb_valid),
        .o_wb_wd        (o_wb_wd),
        .o_wb_wreg      (o_wb_wreg),
        .o_wb_wdata     (o_wb_wdata),
        .o_wb_excepttype(o_wb_excepttype),
        .o_wb_cp0_epc   (o_wb_cp0_epc)
    );

    function automatic logic [31:0] fill_word(input int idx);
        logic [3:0] lo;
        lo = idx[3:0];
        return {4{4'he, lo}};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // APB memory with 0 to 3 wait states per transfer
    always @(posedge clk) begin : apb_memory
        int unsigned waits;
        if (rst) begin
            i_pready <= 1'b0;
            i_prdata <= '0;
            wait_cnt <= 0;
            for (int w = 0; w < 16; w++) begin
                mem[w] <= fill_word(w);
            end
        end else if (o_psel && !o_penable) begin
            waits = $urandom % 4;
            if (waits == 0) begin
                i_pready <= 1'b1;
                i_prdata <= mem[o_paddr[5:2]];
            end
            wait_cnt <= waits;
        end else if (o_psel && o_penable) begin
            if (i_pready) begin
                i_pready <= 1'b0;
                if (o_pwrite) begin
                    for (int b = 0; b < 4; b++) begin
                        if (o_pstrb[b]) begin
                            mem[o_paddr[5:2]][8*b +: 8] <= o_pwdata[8*b +: 8];
                        end
                    end
                end
            end else if (wait_cnt == 1) begin
                i_pready <= 1'b1;
                i_prdata <= mem[o_paddr[5:2]];
                wait_cnt <= 0;
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%08h expected 0x%08h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic add_mem_row(input logic [7:0] op, input logic [31:0] addr,
                               input logic [31:0] reg2, input logic [31:0] exp_wdata,
                               input logic chk_mem, input logic [31:0] exp_mem,
                               input logic no_xfer);
        row_t r;
        r           = '0;
        r.op        = op;
        r.addr      = addr;
        r.reg2      = reg2;
        r.inst_addr = pc_val;
        r.exp_wdata = exp_wdata;
        r.exp_epc   = cp0_epc_val;
        r.chk_mem   = chk_mem;
        r.exp_mem   = exp_mem;
        r.no_xfer   = no_xfer;
        rows.push_back(r);
    endtask

    // Excepting stores target word 5 and must leave its fill value
    task automatic add_exc_row(input logic [7:0] op, input logic [31:0] flags,
                               input logic [31:0] inst_addr, input logic [31:0] status,
                               input logic [31:0] cause, input logic wb_we,
                               input logic [4:0] wb_addr, input logic [31:0] wb_data,
                               input logic [31:0] exp_exc, input logic [31:0] exp_epc);
        row_t r;
        r           = '0;
        r.op        = op;
        r.addr      = 32'h14;
        r.reg2      = 32'hdead_beef;
        r.flags     = flags;
        r.inst_addr = inst_addr;
        r.status    = status;
        r.cause     = cause;
        r.wb_we     = wb_we;
        r.wb_addr   = wb_addr;
        r.wb_data   = wb_data;
        r.exp_wdata = alu_result;
        r.exp_exc   = exp_exc;
        r.exp_epc   = exp_epc;
        r.chk_mem   = (op == aluop_sw);
        r.exp_mem   = 32'he5e5_e5e5;
        r.no_xfer   = 1'b1;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // Word 2 starts as e2e2e2e2 and word 3 as e3e3e3e3
        add_mem_row(aluop_sb, 32'h08, 32'h1234_5655, alu_result, 1, 32'h55e2_e2e2, 0);
        add_mem_row(aluop_sb, 32'h09, 32'h0000_0066, alu_result, 1, 32'h5566_e2e2, 0);
        add_mem_row(aluop_sb, 32'h0a, 32'h0000_0077, alu_result, 1, 32'h5566_77e2, 0);
        add_mem_row(aluop_sb, 32'h0b, 32'h00ab_cd88, alu_result, 1, 32'h5566_7788, 0);
        add_mem_row(aluop_sh, 32'h0c, 32'h5555_abcd, alu_result, 1, 32'habcd_e3e3, 0);
        add_mem_row(aluop_sh, 32'h0e, 32'h0000_1234, alu_result, 1, 32'habcd_1234, 0);
        add_mem_row(aluop_sw, 32'h10, 32'h8a7f_c301, alu_result, 1, 32'h8a7f_c301, 0);
        // Misaligned
        add_mem_row(aluop_sh, 32'h0d, 32'h0000_ffff, alu_result, 1, 32'habcd_1234, 1);
        add_mem_row(aluop_sh, 32'h0f, 32'h0000_ffff, alu_result, 1, 32'habcd_1234, 1);
        add_mem_row(aluop_sw, 32'h0d, 32'hffff_ffff, alu_result, 1, 32'habcd_1234, 1);
        add_mem_row(aluop_sw, 32'h0e, 32'hffff_ffff, alu_result, 1, 32'habcd_1234, 1);
        add_mem_row(aluop_sw, 32'h0f, 32'hffff_ffff, alu_result, 1, 32'habcd_1234, 1);
        add_mem_row(aluop_lh, 32'h11, 32'h0, 32'h0, 0, 32'h0, 1);
        add_mem_row(aluop_lhu, 32'h13, 32'h0, 32'h0, 0, 32'h0, 1);
        add_mem_row(aluop_lw, 32'h12, 32'h0, 32'h0, 0, 32'h0, 1);
        // Loads from 8a7fc301
        add_mem_row(aluop_lb, 32'h10, 32'h0, 32'hffff_ff8a, 0, 32'h0, 0);
        add_mem_row(aluop_lb, 32'h11, 32'h0, 32'h0000_007f, 0, 32'h0, 0);
        add_mem_row(aluop_lb, 32'h12, 32'h0, 32'hffff_ffc3, 0, 32'h0, 0);
        add_mem_row(aluop_lb, 32'h13, 32'h0, 32'h0000_0001, 0, 32'h0, 0);
        add_mem_row(aluop_lbu, 32'h10, 32'h0, 32'h0000_008a, 0, 32'h0, 0);
        add_mem_row(aluop_lbu, 32'h11, 32'h0, 32'h0000_007f, 0, 32'h0, 0);
        add_mem_row(aluop_lbu, 32'h12, 32'h0, 32'h0000_00c3, 0, 32'h0, 0);
        add_mem_row(aluop_lbu, 32'h13, 32'h0, 32'h0000_0001, 0, 32'h0, 0);
        add_mem_row(aluop_lh, 32'h10, 32'h0, 32'hffff_8a7f, 0, 32'h0, 0);
        add_mem_row(aluop_lh, 32'h12, 32'h0, 32'hffff_c301, 0, 32'h0, 0);
        add_mem_row(aluop_lhu, 32'h10, 32'h0, 32'h0000_8a7f, 0, 32'h0, 0);
        add_mem_row(aluop_lhu, 32'h12, 32'h0, 32'h0000_c301, 0, 32'h0, 0);
        add_mem_row(aluop_lw, 32'h10, 32'h0, 32'h8a7f_c301, 0, 32'h0, 0);
        add_mem_row(aluop_lw, 32'h3c, 32'h0, 32'hefef_efef, 0, 32'h0, 0);
        add_mem_row(op_addu, 32'h20, 32'h0, alu_result, 0, 32'h0, 1);
        // Exception priority
        add_exc_row(aluop_sw, 32'h0100, pc_val, 32'h0, 32'h0400,
                    1, 5'd12, 32'h0401, 32'd1, cp0_epc_val);
        add_exc_row(aluop_sw, 32'h0100, pc_val, 32'h0, 32'h0400,
                    0, 5'd12, 32'h0401, 32'd8, cp0_epc_val);
        add_exc_row(aluop_sw, 32'h0600, pc_val, 32'h0403, 32'h0400,
                    0, 5'd0, 32'h0, 32'd10, cp0_epc_val);
        add_exc_row(aluop_sw, 32'h0, pc_val, 32'h0101, 32'h0,
                    1, 5'd13, 32'h0100, 32'd1, cp0_epc_val);
        add_exc_row(aluop_sw, 32'h0c00, pc_val, 32'h0, 32'h0,
                    0, 5'd0, 32'h0, 32'd13, cp0_epc_val);
        add_exc_row(aluop_sw, 32'h1800, pc_val, 32'h0, 32'h0,
                    0, 5'd0, 32'h0, 32'd12, cp0_epc_val);
        add_exc_row(aluop_sw, 32'h1000, pc_val, 32'h0, 32'h0,
                    0, 5'd0, 32'h0, 32'd14, cp0_epc_val);
        add_exc_row(aluop_sw, 32'h1f00, pc_val, 32'h0, 32'h0,
                    0, 5'd0, 32'h0, 32'd8, cp0_epc_val);
        add_exc_row(op_addu, 32'h0100, 32'h0, 32'h0401, 32'h0400,
                    0, 5'd0, 32'h0, 32'd0, cp0_epc_val);
        // EPC forwarding
        add_exc_row(op_addu, 32'h0, pc_val, 32'h0, 32'h0,
                    1, 5'd14, 32'h0000_beef, 32'd0, 32'h0000_beef);
        add_exc_row(op_addu, 32'h0, pc_val, 32'h0, 32'h0,
                    0, 5'd14, 32'h0000_beef, 32'd0, cp0_epc_val);
    endtask

    task automatic run_row(input row_t r, input int idx);
        int   cycles;
        logic saw_psel;
        cycles   = 0;
        saw_psel = 1'b0;
        @(posedge clk);
        i_valid       <= 1'b1;
        i_aluop       <= r.op;
        i_addr        <= r.addr;
        i_reg2        <= r.reg2;
        i_wd          <= idx[4:0];
        i_wreg        <= idx[0];
        i_excepttype  <= r.flags;
        i_inst_addr   <= r.inst_addr;
        i_cp0_status  <= r.status;
        i_cp0_cause   <= r.cause;
        i_wb_cp0_we   <= r.wb_we;
        i_wb_cp0_addr <= r.wb_addr;
        i_wb_cp0_data <= r.wb_data;
        @(negedge clk);
        compare_word("o_ready", 32'(o_ready), 32'd1);
        @(posedge clk);
        i_valid <= 1'b0;
        // Fields stay on the inputs until writeback
        do begin
            @(negedge clk);
            cycles++;
            saw_psel = saw_psel | o_psel;
            if (!o_wb_valid) begin
                compare_word("o_ready", 32'(o_ready), 32'd0);
            end
        end while (!o_wb_valid);
        if (r.no_xfer) begin
            compare_word("wb latency", cycles, 32'd1);
        end
        compare_word("o_psel seen", 32'(saw_psel), 32'(!r.no_xfer));
        compare_word("o_wb_wdata", o_wb_wdata, r.exp_wdata);
        compare_word("o_wb_excepttype", o_wb_excepttype, r.exp_exc);
        compare_word("o_wb_cp0_epc", o_wb_cp0_epc, r.exp_epc);
        compare_word("o_wb_wd", 32'(o_wb_wd), 32'(idx[4:0]));
        compare_word("o_wb_wreg", 32'(o_wb_wreg), 32'(idx[0]));
        if (r.chk_mem) begin
            compare_word("mem word", mem[r.addr[5:2]], r.exp_mem);
        end
        @(negedge clk);
        compare_word("o_wb_valid", 32'(o_wb_valid), 32'd0);
    endtask

    initial begin
        void'($urandom(32'h9cc3_c95d));
        rst           <= 1'b1;
        i_valid       <= 1'b0;
        i_aluop       <= '0;
        i_addr        <= '0;
        i_reg2        <= '0;
        i_wd          <= '0;
        i_wreg        <= 1'b1;
        i_wdata       <= alu_result;
        i_excepttype  <= '0;
        i_inst_addr   <= '0;
        i_cp0_status  <= '0;
        i_cp0_cause   <= '0;
        i_cp0_epc     <= cp0_epc_val;
        i_wb_cp0_we   <= 1'b0;
        i_wb_cp0_addr <= '0;
        i_wb_cp0_data <= '0;
        build_table();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_word("o_psel", 32'(o_psel), 32'd0);
        compare_word("o_penable", 32'(o_penable), 32'd0);
        compare_word("o_pwrite", 32'(o_pwrite), 32'd0);
        compare_word("o_wb_valid", 32'(o_wb_valid), 32'd0);
        compare_word("o_ready", 32'(o_ready), 32'd1);
        for (int n = 0; n < rows.size(); n++) begin
            run_row(rows[n], n);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // Watchdog sized once the table is filled
    initial begin
        int unsigned limit_cycles;
        #1;
        limit_cycles = 40 * rows.size() + 20;
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== tb/mem_stage_properties.sv ====
`timescale 1ns/10ps

module mem_stage_properties #(
    parameter int ADDR_W = 32
) (
    input logic              clk,
    input logic              rst,
    input logic              i_valid,
    input logic              o_ready,
    input logic              o_psel,
    input logic              o_penable,
    input logic              o_pwrite,
    input logic [ADDR_W-1:0] o_paddr,
    input logic [3:0]        o_pstrb,
    input logic [31:0]       o_pwdata,
    input logic              i_pready,
    input logic [31:0]       exc_code
);

    // Access phase only follows a setup cycle
    penable_after_setup: assert property (@(posedge clk) disable iff (rst)
        $rose(o_penable) |-> (o_psel && $past(o_psel)))
        else $error("o_penable rose without a preceding setup cycle");

    // Request stays put until the completer answers
    apb_hold_until_ready: assert property (@(posedge clk) disable iff (rst)
        (o_psel && !(o_penable && i_pready)) |=>
            (o_psel && $stable(o_paddr) && $stable(o_pwrite)
             && $stable(o_pstrb) && $stable(o_pwdata)))
        else $error("APB request changed before i_pready");

    no_xfer_on_exception: assert property (@(posedge clk) disable iff (rst)
        (i_valid && o_ready && (exc_code != 32'b0)) |=> !o_psel)
        else $error("bus transfer started for an excepting instruction");

endmodule

bind mem_stage mem_stage_properties #(.ADDR_W(ADDR_W)) u_props (
    .clk      (clk),
    .rst      (rst),
    .i_valid  (i_valid),
    .o_ready  (o_ready),
    .o_psel   (o_psel),
    .o_penable(o_penable),
    .o_pwrite (o_pwrite),
    .o_paddr  (o_paddr),
    .o_pstrb  (o_pstrb),
    .o_pwdata (o_pwdata),
    .i_pready (i_pready),
    .exc_code (exc_code)
);

// ==== rtl/mem_stage.sv ====
`timescale 1ns/10ps

module mem_stage #(
    parameter int ADDR_W = 32
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             i_valid,
    output logic                             o_ready,
    input  logic [mem_isa_pkg::ALUOP_W-1:0]  i_aluop,
    input  logic [ADDR_W-1:0]                i_addr,
    input  logic [31:0]                      i_reg2,
    input  logic [4:0]                       i_wd,
    input  logic                             i_wreg,
    input  logic [31:0]                      i_wdata,
    input  logic [31:0]                      i_excepttype,
    input  logic [31:0]                      i_inst_addr,
    input  logic [31:0]                      i_cp0_status,
    input  logic [31:0]                      i_cp0_cause,
    input  logic [31:0]                      i_cp0_epc,
    input  logic                             i_wb_cp0_we,
    input  logic [cp0_pkg::CP0_ADDR_W-1:0]   i_wb_cp0_addr,
    input  logic [31:0]                      i_wb_cp0_data,
    output logic [ADDR_W-1:0]                o_paddr,
    output logic                             o_psel,
    output logic                             o_penable,
    output logic                             o_pwrite,
    output logic [3:0]                       o_pstrb,
    output logic [31:0]                      o_pwdata,
    input  logic [31:0]                      i_prdata,
    input  logic                             i_pready,
    output logic                             o_wb_valid,
    output logic [4:0]                       o_wb_wd,
    output logic                             o_wb_wreg,
    output logic [31:0]                      o_wb_wdata,
    output logic [31:0]                      o_wb_excepttype,
    output logic [31:0]                      o_wb_cp0_epc
);
    import cp0_pkg::*;

    cp0_word_u   status_fwd;
    cp0_word_u   cause_fwd;
    logic [31:0] epc_fwd;
    logic [31:0] exc_code;
    logic        is_mem;
    logic        is_store;
    logic        misaligned;
    logic [3:0]  strb;
    logic [31:0] store_data;
    logic [31:0] load_data;
    logic [31:0] bus_rdata;

    cp0_bypass u_cp0_bypass (
        .i_cp0_status (i_cp0_status),
        .i_cp0_cause  (i_cp0_cause),
        .i_cp0_epc    (i_cp0_epc),
        .i_wb_cp0_we  (i_wb_cp0_we),
        .i_wb_cp0_addr(i_wb_cp0_addr),
        .i_wb_cp0_data(i_wb_cp0_data),
        .o_status     (status_fwd),
        .o_cause      (cause_fwd),
        .o_epc        (epc_fwd)
    );

    except_resolve u_except_resolve (
        .i_status    (status_fwd),
        .i_cause     (cause_fwd),
        .i_excepttype(i_excepttype),
        .i_inst_addr (i_inst_addr),
        .o_excepttype(exc_code)
    );

    // Instruction fields stay on the inputs until o_wb_valid
    mem_access_format u_format (
        .i_aluop     (i_aluop),
        .i_addr_lo   (i_addr[1:0]),
        .i_reg2      (i_reg2),
        .i_rdata     (bus_rdata),
        .o_is_mem    (is_mem),
        .o_is_store  (is_store),
        .o_misaligned(misaligned),
        .o_strb      (strb),
        .o_store_data(store_data),
        .o_load_data (load_data)
    );

    mem_access_ctrl #(
        .ADDR_W(ADDR_W)
    ) u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .i_valid        (i_valid),
        .o_ready        (o_ready),
        .i_wd           (i_wd),
        .i_wreg         (i_wreg),
        .i_wdata        (i_wdata),
        .i_excepttype   (exc_code),
        .i_epc          (epc_fwd),
        .i_addr         (i_addr),
        .i_is_mem       (is_mem),
        .i_is_store     (is_store),
        .i_misaligned   (misaligned),
        .i_strb         (strb),
        .i_store_data   (store_data),
        .i_load_data    (load_data),
        .o_rdata        (bus_rdata),
        .o_paddr        (o_paddr),
        .o_psel         (o_psel),
        .o_penable      (o_penable),
        .o_pwrite       (o_pwrite),
        .o_pstrb        (o_pstrb),
        .o_pwdata       (o_pwdata),
        .i_prdata       (i_prdata),
        .i_pready       (i_pready),
        .o_wb_valid     (o_wb_valid),
        .o_wb_wd        (o_wb_wd),
        .o_wb_wreg      (o_wb_wreg),
        .o_wb_wdata     (o_wb_wdata),
        .o_wb_excepttype(o_wb_excepttype),
        .o_wb_cp0_epc   (o_wb_cp0_epc)
    );

endmodule

// ==== rtl/mem_access_ctrl.sv ====
`timescale 1ns/10ps

module mem_access_ctrl #(
    parameter int ADDR_W = 32
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_valid,
    output logic                           o_ready,
    input  logic [4:0]                     i_wd,
    input  logic                           i_wreg,
    input  logic [31:0]                    i_wdata,
    input  logic [31:0]                    i_excepttype,
    input  logic [31:0]                    i_epc,
    input  logic [ADDR_W-1:0]              i_addr,
    input  logic                           i_is_mem,
    input  logic                           i_is_store,
    input  logic                           i_misaligned,
    input  logic [mem_isa_pkg::STRB_W-1:0] i_strb,
    input  logic [mem_isa_pkg::WORD_W-1:0] i_store_data,
    input  logic [mem_isa_pkg::WORD_W-1:0] i_load_data,
    output logic [mem_isa_pkg::WORD_W-1:0] o_rdata,
    output logic [ADDR_W-1:0]              o_paddr,
    output logic                           o_psel,
    output logic                           o_penable,
    output logic                           o_pwrite,
    output logic [mem_isa_pkg::STRB_W-1:0] o_pstrb,
    output logic [mem_isa_pkg::WORD_W-1:0] o_pwdata,
    input  logic [mem_isa_pkg::WORD_W-1:0] i_prdata,
    input  logic                           i_pready,
    output logic                           o_wb_valid,
    output logic [4:0]                     o_wb_wd,
    output logic                           o_wb_wreg,
    output logic [31:0]                    o_wb_wdata,
    output logic [31:0]                    o_wb_excepttype,
    output logic [31:0]                    o_wb_cp0_epc
);
    import cp0_pkg::*;

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_SETUP  = 2'd1;
    localparam logic [1:0] ST_ACCESS = 2'd2;

    logic [1:0] state;
    logic       accept;
    logic       start_xfer;
    logic       done;

    assign o_ready    = (state == ST_IDLE);
    assign accept     = i_valid && o_ready;
    // Faulting or misaligned accesses never reach the bus
    assign start_xfer = i_is_mem && !i_misaligned && (i_excepttype == exc_none);
    assign done       = (state == ST_ACCESS) && i_pready;
    assign o_rdata    = (state == ST_ACCESS) ? i_prdata : '0;

    ////////////////////////////////////////////////////////////////////////////
    // APB sequencing
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            o_psel     <= 1'b0;
            o_penable  <= 1'b0;
            o_pwrite   <= 1'b0;
            o_wb_valid <= 1'b0;
            o_wb_wreg  <= 1'b0;
        end else begin
            o_wb_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        o_wb_wreg <= i_wreg;
                        if (start_xfer) begin
                            state    <= ST_SETUP;
                            o_psel   <= 1'b1;
                            o_pwrite <= i_is_store;
                        end else begin
                            o_wb_valid <= 1'b1;
                        end
                    end
                end
                ST_SETUP: begin
                    state     <= ST_ACCESS;
                    o_penable <= 1'b1;
                end
                ST_ACCESS: begin
                    if (i_pready) begin
                        state      <= ST_IDLE;
                        o_psel     <= 1'b0;
                        o_penable  <= 1'b0;
                        o_pwrite   <= 1'b0;
                        o_wb_valid <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Transfer payload and writeback result
    always_ff @(posedge clk) begin
        if (accept) begin
            o_wb_wd         <= i_wd;
            o_wb_excepttype <= i_excepttype;
            o_wb_cp0_epc    <= i_epc;
            o_wb_wdata      <= (i_is_mem && !i_is_store && i_misaligned) ? '0 : i_wdata;
            if (start_xfer) begin
                o_paddr  <= i_addr;
                o_pstrb  <= i_strb;
                o_pwdata <= i_store_data;
            end
        end else if (done && !o_pwrite) begin
            o_wb_wdata <= i_load_data;
        end
    end

endmodule

// ==== rtl/mem_access_format.sv ====
`timescale 1ns/10ps

module mem_access_format (
    input  logic [mem_isa_pkg::ALUOP_W-1:0] i_aluop,
    input  logic [1:0]                      i_addr_lo,
    input  logic [mem_isa_pkg::WORD_W-1:0]  i_reg2,
    input  logic [mem_isa_pkg::WORD_W-1:0]  i_rdata,
    output logic                            o_is_mem,
    output logic                            o_is_store,
    output logic                            o_misaligned,
    output logic [mem_isa_pkg::STRB_W-1:0]  o_strb,
    output logic [mem_isa_pkg::WORD_W-1:0]  o_store_data,
    output logic [mem_isa_pkg::WORD_W-1:0]  o_load_data
);
    import mem_isa_pkg::*;

    logic       sz_byte;
    logic       sz_half;
    logic       is_signed;
    logic [7:0] byte_lane;
    logic [15:0] half_lane;

    ////////////////////////////////////////////////////////////////////////////
    // Operation decode
    always_comb begin
        o_is_mem   = 1'b1;
        o_is_store = 1'b0;
        sz_byte    = 1'b0;
        sz_half    = 1'b0;
        is_signed  = 1'b0;
        case (i_aluop)
            aluop_lb:  begin sz_byte = 1'b1; is_signed = 1'b1; end
            aluop_lbu: sz_byte = 1'b1;
            aluop_lh:  begin sz_half = 1'b1; is_signed = 1'b1; end
            aluop_lhu: sz_half = 1'b1;
            aluop_lw:  ;
            aluop_sb:  begin sz_byte = 1'b1; o_is_store = 1'b1; end
            aluop_sh:  begin sz_half = 1'b1; o_is_store = 1'b1; end
            aluop_sw:  o_is_store = 1'b1;
            default:   o_is_mem = 1'b0;
        endcase
    end

    // Big-endian lanes with offset 0 in bits 31:24
    always_comb begin
        o_strb       = '0;
        o_misaligned = 1'b0;
        if (o_is_mem) begin
            if (sz_byte) begin
                o_strb = 4'b1000 >> i_addr_lo;
            end else if (sz_half) begin
                case (i_addr_lo)
                    2'b00:   o_strb = 4'b1100;
                    2'b10:   o_strb = 4'b0011;
                    default: o_misaligned = 1'b1;
                endcase
            end else if (i_addr_lo == 2'b00) begin
                o_strb = 4'b1111;
            end else begin
                o_misaligned = 1'b1;
            end
        end
    end

    // Replicate across lanes and let the strobes pick
    always_comb begin
        if (!o_is_store) begin
            o_store_data = '0;
        end else if (sz_byte) begin
            o_store_data = {4{i_reg2[7:0]}};
        end else if (sz_half) begin
            o_store_data = {2{i_reg2[15:0]}};
        end else begin
            o_store_data = i_reg2;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Load extraction
    assign byte_lane = i_rdata[8*(3 - i_addr_lo) +: 8];
    assign half_lane = i_addr_lo[1] ? i_rdata[15:0] : i_rdata[31:16];

    always_comb begin
        if (!o_is_mem || o_is_store || o_misaligned) begin
            o_load_data = '0;
        end else if (sz_byte) begin
            o_load_data = {{24{is_signed & byte_lane[7]}}, byte_lane};
        end else if (sz_half) begin
            o_load_data = {{16{is_signed & half_lane[15]}}, half_lane};
        end else begin
            o_load_data = i_rdata;
        end
    end

endmodule

// ==== rtl/except_resolve.sv ====
`timescale 1ns/10ps

module except_resolve (
    input  cp0_pkg::cp0_word_u i_status,
    input  cp0_pkg::cp0_word_u i_cause,
    input  logic [31:0]        i_excepttype,
    input  logic [31:0]        i_inst_addr,
    output logic [31:0]        o_excepttype
);
    import cp0_pkg::*;

    logic int_pending;

    // Pending and unmasked, outside exception level, globally enabled
    assign int_pending = (|(i_cause.irq.int_bits & i_status.irq.int_bits))
                         && !i_status.irq.exl
                         && i_status.irq.ie;

    always_comb begin
        o_excepttype = exc_none;
        // A bubble carries address zero and never faults
        if (i_inst_addr != 32'b0) begin
            if (int_pending) begin
                o_excepttype = exc_interrupt;
            end else if (i_excepttype[exc_bit_syscall]) begin
                o_excepttype = exc_syscall;
            end else if (i_excepttype[exc_bit_invalid]) begin
                o_excepttype = exc_inst_invalid;
            end else if (i_excepttype[exc_bit_trap]) begin
                o_excepttype = exc_trap;
            end else if (i_excepttype[exc_bit_ov]) begin
                o_excepttype = exc_overflow;
            end else if (i_excepttype[exc_bit_eret]) begin
                o_excepttype = exc_eret;
            end
        end
    end

endmodule

// ==== rtl/cp0_bypass.sv ====
`timescale 1ns/10ps

module cp0_bypass (
    input  logic [31:0]                   i_cp0_status,
    input  logic [31:0]                   i_cp0_cause,
    input  logic [31:0]                   i_cp0_epc,
    input  logic                          i_wb_cp0_we,
    input  logic [cp0_pkg::CP0_ADDR_W-1:0] i_wb_cp0_addr,
    input  logic [31:0]                   i_wb_cp0_data,
    output cp0_pkg::cp0_word_u            o_status,
    output cp0_pkg::cp0_word_u            o_cause,
    output logic [31:0]                   o_epc
);
    import cp0_pkg::*;

    logic wr_status;
    logic wr_cause;
    logic wr_epc;

    assign wr_status = i_wb_cp0_we && (i_wb_cp0_addr == cp0_reg_status);
    assign wr_cause  = i_wb_cp0_we && (i_wb_cp0_addr == cp0_reg_cause);
    assign wr_epc    = i_wb_cp0_we && (i_wb_cp0_addr == cp0_reg_epc);

    assign o_status.raw = wr_status ? i_wb_cp0_data : i_cp0_status;
    assign o_epc        = wr_epc ? i_wb_cp0_data : i_cp0_epc;

    always_comb begin
        o_cause.raw = i_cp0_cause;
        // Only the software interrupt bits and IV/WP are writable
        if (wr_cause) begin
            o_cause.raw[9:8]   = i_wb_cp0_data[9:8];
            o_cause.raw[23:22] = i_wb_cp0_data[23:22];
        end
    end

endmodule

// ==== rtl/cp0_pkg.sv ====
package cp0_pkg;

    localparam int CP0_ADDR_W = 5;

    // CP0 register numbers
    localparam logic [CP0_ADDR_W-1:0] cp0_reg_status = 5'd12;
    localparam logic [CP0_ADDR_W-1:0] cp0_reg_cause  = 5'd13;
    localparam logic [CP0_ADDR_W-1:0] cp0_reg_epc    = 5'd14;

    ////////////////////////////////////////////////////////////////////////////
    // Exception codes handed to writeback
    localparam logic [31:0] exc_none         = 32'h0000_0000;
    localparam logic [31:0] exc_interrupt    = 32'h0000_0001;
    localparam logic [31:0] exc_syscall      = 32'h0000_0008;
    localparam logic [31:0] exc_inst_invalid = 32'h0000_000a;
    localparam logic [31:0] exc_overflow     = 32'h0000_000c;
    localparam logic [31:0] exc_trap         = 32'h0000_000d;
    localparam logic [31:0] exc_eret         = 32'h0000_000e;

    // Flag positions in the incoming exception word
    localparam int exc_bit_syscall = 8;
    localparam int exc_bit_invalid = 9;
    localparam int exc_bit_trap    = 10;
    localparam int exc_bit_ov      = 11;
    localparam int exc_bit_eret    = 12;

    // Status and cause share the interrupt field layout
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [15:0] hi16;
            logic [7:0]  int_bits;
            logic [5:0]  mid;
            logic        exl;
            logic        ie;
        } irq;
    } cp0_word_u;

endpackage

// ==== rtl/mem_isa_pkg.sv ====
package mem_isa_pkg;

    // Widths shared by the memory stage
    localparam int ALUOP_W = 8;
    localparam int STRB_W  = 4;
    localparam int WORD_W  = 32;

    ////////////////////////////////////////////////////////////////////////////
    // Execute-stage operation codes for the load/store group

    // Loads
    localparam logic [ALUOP_W-1:0] aluop_lb  = 8'b1110_0000;
    localparam logic [ALUOP_W-1:0] aluop_lh  = 8'b1110_0001;
    localparam logic [ALUOP_W-1:0] aluop_lw  = 8'b1110_0011;
    localparam logic [ALUOP_W-1:0] aluop_lbu = 8'b1110_0100;
    localparam logic [ALUOP_W-1:0] aluop_lhu = 8'b1110_0101;

    // Stores
    localparam logic [ALUOP_W-1:0] aluop_sb  = 8'b1110_1000;
    localparam logic [ALUOP_W-1:0] aluop_sh  = 8'b1110_1001;
    localparam logic [ALUOP_W-1:0] aluop_sw  = 8'b1110_1011;

endpackage
